/* hw/board_engine.sv */
`timescale 1ns/100ps

module board_engine (
  input  logic clk,
  input  logic rst_n,
  move_if.dst moves,
  output game_pkg::board_t board
);
  import game_pkg::*;

  typedef tile_t [3:0] line_t;  // index 0 is the head

  // compact toward the head, then merge pairs once, head first
  function automatic line_t slide_merge(input line_t line_in);
    tile_t [4:0] packed_l;  // spare zero past the tail
    line_t line_out;
    logic [2:0] n;
    logic [2:0] k;
    logic skip;
    packed_l = '0;
    line_out = '0;
    n = '0;
    k = '0;
    skip = 1'b0;
    for (int i = 0; i < 4; i++) begin
      if (line_in[i] != '0) begin
        packed_l[n] = line_in[i];
        n = n + 3'd1;
      end
    end
    for (int i = 0; i < 4; i++) begin
      if (skip) begin
        skip = 1'b0;  // partner already merged
      end else if (packed_l[i] != '0) begin
        if (packed_l[i] == packed_l[i+1] && packed_l[i] < max_tile) begin
          line_out[k[1:0]] = packed_l[i] + 4'd1;
          skip = 1'b1;
        end else begin
          line_out[k[1:0]] = packed_l[i];
        end
        k = k + 3'd1;
      end
    end
    return line_out;
  endfunction

  // dir 0 up (y=0), 1 down (y=3), 2 left (x=0), 3 right (x=3)
  function automatic board_t apply_move(input board_t b_in, input logic [1:0] dir);
    board_t b_out;
    line_t line;
    b_out = b_in;
    for (int j = 0; j < 4; j++) begin
      for (int i = 0; i < 4; i++) begin
        case (dir)
          2'd0:    line[i] = b_in[j][i];
          2'd1:    line[i] = b_in[j][3-i];
          2'd2:    line[i] = b_in[i][j];
          default: line[i] = b_in[3-i][j];
        endcase
      end
      line = slide_merge(line);
      for (int i = 0; i < 4; i++) begin
        case (dir)
          2'd0:    b_out[j][i] = line[i];
          2'd1:    b_out[j][3-i] = line[i];
          2'd2:    b_out[i][j] = line[i];
          default: b_out[3-i][j] = line[i];
        endcase
      end
    end
    return b_out;
  endfunction

  logic [1:0] dir;
  logic any_move;
  board_t moved;
  logic changed;          // last move altered the board
  logic [7:0] lfsr;
  logic [4:0] empty_cnt;
  logic [3:0] spawn_pos;  // x*4 + y
  logic spawn_en;
  tile_t spawn_val;

  // priority up, down, left, right
  always_comb begin
    any_move = moves.up | moves.down | moves.left | moves.right;
    if (moves.up) begin
      dir = 2'd0;
    end else if (moves.down) begin
      dir = 2'd1;
    end else if (moves.left) begin
      dir = 2'd2;
    end else begin
      dir = 2'd3;
    end
  end

  assign moved = apply_move(board, dir);

  // count empties, then take the (lfsr mod count)-th one, x major
  always_comb begin : spawn_pick
    logic [4:0] target;
    logic [4:0] seen;
    empty_cnt = '0;
    for (int c = 0; c < 16; c++) begin
      if (board[c/4][c%4] == '0) begin
        empty_cnt = empty_cnt + 5'd1;
      end
    end
    target = '0;
    if (empty_cnt != '0) begin
      target = 5'(lfsr % {3'b000, empty_cnt});
    end
    seen = '0;
    spawn_pos = '0;
    for (int c = 0; c < 16; c++) begin
      if (board[c/4][c%4] == '0) begin
        if (seen == target) begin
          spawn_pos = 4'(c);
        end
        seen = seen + 5'd1;
      end
    end
  end

  assign spawn_en  = changed && (empty_cnt != '0);
  assign spawn_val = (lfsr < spawn_four_limit) ? 4'd1 : 4'd2;  // mostly 2s

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      board       <= '0;
      board[1][1] <= 4'd1;  // two starting tiles
      board[2][2] <= 4'd1;
      changed     <= 1'b0;
      lfsr        <= lfsr_seed;
    end else begin
      lfsr    <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};  // free running
      changed <= 1'b0;
      if (spawn_en) begin
        board[spawn_pos[3:2]][spawn_pos[1:0]] <= spawn_val;  // edge t+2
      end else if (any_move) begin
        board   <= moved;            // edge t+1
        changed <= (moved != board);
      end
    end
  end

endmodule

/* hw/game_2048_top.sv */
`timescale 1ns/100ps

module game_2048_top #(
  parameter int h_active = 640,
  parameter int h_front  = 16,
  parameter int h_sync   = 96,
  parameter int h_back   = 48,
  parameter int v_active = 480,
  parameter int v_front  = 10,
  parameter int v_sync   = 2,
  parameter int v_back   = 33,
  parameter int cell_w   = 160,
  parameter int cell_h   = 120,
  parameter int border_w = 4
) (
  input  logic clk,
  input  logic rst_n,
  input  logic pmod_data,
  input  logic pmod_clk,
  input  logic pmod_latch,
  output logic hsync,
  output logic vsync,
  output logic [1:0] red,
  output logic [1:0] green,
  output logic [1:0] blue
);
  import game_pkg::*;

  localparam int h_total = h_active + h_front + h_sync + h_back;
  localparam int v_total = v_active + v_front + v_sync + v_back;
  // wide enough for the longer of the two counters
  localparam int coord_w = $clog2((h_total > v_total) ? h_total : v_total);

  pad_word_u pad_word;  // latched frame
  logic present;
  board_t board;

  move_if moves_i ();
  pixel_if #(.coord_w(coord_w)) pix_i ();

  pad_receiver pad_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .pmod_data  (pmod_data),
    .pmod_clk   (pmod_clk),
    .pmod_latch (pmod_latch),
    .pad_word   (pad_word),
    .present    (present)
  );

  move_detect move_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .pad_word (pad_word),
    .present  (present),
    .moves    (moves_i.src)
  );

  board_engine board_i (
    .clk   (clk),
    .rst_n (rst_n),
    .moves (moves_i.dst),
    .board (board)
  );

  vga_timing #(
    .h_active (h_active),
    .h_front  (h_front),
    .h_sync   (h_sync),
    .h_back   (h_back),
    .v_active (v_active),
    .v_front  (v_front),
    .v_sync   (v_sync),
    .v_back   (v_back),
    .coord_w  (coord_w)
  ) timing_i (
    .clk   (clk),
    .rst_n (rst_n),
    .pix   (pix_i.src)
  );

  tile_renderer #(
    .h_active (h_active),
    .v_active (v_active),
    .cell_w   (cell_w),
    .cell_h   (cell_h),
    .border_w (border_w),
    .coord_w  (coord_w)
  ) render_i (
    .clk   (clk),
    .rst_n (rst_n),
    .pix   (pix_i.dst),
    .board (board),
    .hsync (hsync),
    .vsync (vsync),
    .red   (red),
    .green (green),
    .blue  (blue)
  );

endmodule

/* hw/game_if.sv */
`timescale 1ns/100ps

// one-cycle move strobes, never stalled
interface move_if;
  logic up;
  logic down;
  logic left;
  logic right;

  modport src (output up, output down, output left, output right);
  modport dst (input up, input down, input left, input right);
endinterface

// raster position plus sync levels, all from the same counters
interface pixel_if #(
  parameter int coord_w = 10
);
  logic [coord_w-1:0] x;
  logic [coord_w-1:0] y;
  logic active;   // inside the visible area
  logic hsync;    // active low
  logic vsync;    // active low

  modport src (output x, output y, output active, output hsync, output vsync);
  modport dst (input x, input y, input active, input hsync, input vsync);
endinterface

/* hw/game_pkg.sv */
package game_pkg;

  localparam int pad_bits = 12;              // one pad, one frame
  localparam int spawn_four_limit = 230;     // lfsr at or above this spawns a 4
  localparam logic [7:0] lfsr_seed = 8'h69;

  typedef logic [3:0] tile_t;                // exponent, 0 means empty
  localparam tile_t max_tile = 4'd11;        // 2048

  // board[x][y], x is the column
  typedef tile_t [3:0][3:0] board_t;

  // frame order, first bit shifted in ends up at the msb
  typedef struct packed {
    logic b;
    logic y;
    logic select;
    logic start;
    logic up;
    logic down;
    logic left;
    logic right;
    logic a;
    logic x;
    logic l;
    logic r;
  } btn_word_t;

  // raw view for latching and the all-ones test, btn view for buttons
  typedef union packed {
    logic [pad_bits-1:0] raw;
    btn_word_t btn;
  } pad_word_u;

  typedef struct packed {
    logic [1:0] red;
    logic [1:0] green;
    logic [1:0] blue;
  } rgb_t;

  localparam rgb_t border_rgb = '{2'b10, 2'b10, 2'b10};  // grey grid

  localparam rgb_t palette [12] = '{
    '{2'b00, 2'b00, 2'b00},  // empty, black
    '{2'b11, 2'b00, 2'b00},  // 2 red
    '{2'b11, 2'b10, 2'b00},  // 4 orange
    '{2'b11, 2'b11, 2'b00},  // 8 yellow
    '{2'b10, 2'b11, 2'b00},  // 16 lime
    '{2'b00, 2'b11, 2'b00},  // 32 green
    '{2'b00, 2'b11, 2'b10},  // 64 teal
    '{2'b00, 2'b11, 2'b11},  // 128 cyan
    '{2'b00, 2'b00, 2'b11},  // 256 blue
    '{2'b11, 2'b00, 2'b11},  // 512 magenta
    '{2'b11, 2'b01, 2'b11},  // 1024 pink
    '{2'b11, 2'b11, 2'b11}   // 2048 white
  };

endpackage

/* hw/move_detect.sv */
`timescale 1ns/100ps

module move_detect (
  input  logic clk,
  input  logic rst_n,
  input  game_pkg::pad_word_u pad_word,
  input  logic present,
  move_if.src moves
);

  logic [3:0] dir_now;   // up, down, left, right
  logic [3:0] dir_prev;
  logic [3:0] dir_new;

  assign dir_now = {pad_word.btn.up, pad_word.btn.down, pad_word.btn.left, pad_word.btn.right};

  // prev follows the raw bits, so leaving the all-ones state is no press
  assign dir_new = dir_now & ~dir_prev & {4{present}};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dir_prev <= 4'hf;  // matches the reset word
      {moves.up, moves.down, moves.left, moves.right} <= 4'h0;
    end else begin
      dir_prev <= dir_now;
      {moves.up, moves.down, moves.left, moves.right} <= dir_new;  // one cycle each
    end
  end

endmodule

/* hw/pad_receiver.sv */
`timescale 1ns/100ps

module pad_receiver (
  input  logic clk,
  input  logic rst_n,
  input  logic pmod_data,
  input  logic pmod_clk,
  input  logic pmod_latch,
  output game_pkg::pad_word_u pad_word,
  output logic present
);
  import game_pkg::*;

  logic [1:0] data_sync;   // two-flop synchronisers
  logic [1:0] clk_sync;
  logic [1:0] latch_sync;
  logic clk_prev;          // for edge detect
  logic latch_prev;
  logic clk_rise;
  logic latch_rise;
  logic [pad_bits-1:0] shift_reg;

  // idle pad lines sit high
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      data_sync  <= 2'b11;
      clk_sync   <= 2'b11;
      latch_sync <= 2'b11;
      clk_prev   <= 1'b1;
      latch_prev <= 1'b1;
    end else begin
      data_sync  <= {data_sync[0], pmod_data};
      clk_sync   <= {clk_sync[0], pmod_clk};
      latch_sync <= {latch_sync[0], pmod_latch};
      clk_prev   <= clk_sync[1];
      latch_prev <= latch_sync[1];
    end
  end

  assign clk_rise   = clk_sync[1] & ~clk_prev;
  assign latch_rise = latch_sync[1] & ~latch_prev;

  // all ones after reset reads as no pad
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      shift_reg    <= '1;
      pad_word.raw <= '1;
    end else begin
      if (clk_rise) begin
        shift_reg <= {shift_reg[pad_bits-2:0], data_sync[1]};  // msb first
      end
      if (latch_rise) begin
        pad_word.raw <= shift_reg;  // 3 cycles after latch pin rises
      end
    end
  end

  // a missing pad shifts in nothing but ones
  assign present = (pad_word.raw != '1);

endmodule

/* hw/tile_renderer.sv */
`timescale 1ns/100ps

module tile_renderer #(
  parameter int h_active = 640,
  parameter int v_active = 480,
  parameter int cell_w   = 160,
  parameter int cell_h   = 120,
  parameter int border_w = 4,
  parameter int coord_w  = 10
) (
  input  logic clk,
  input  logic rst_n,
  pixel_if.dst pix,
  input  game_pkg::board_t board,
  output logic hsync,
  output logic vsync,
  output logic [1:0] red,
  output logic [1:0] green,
  output logic [1:0] blue
);
  import game_pkg::*;

  logic [1:0] cell_x;           // column under the beam
  logic [1:0] cell_y;
  logic [coord_w-1:0] off_x;    // offset inside the cell
  logic [coord_w-1:0] off_y;
  logic border;
  tile_t tile;
  rgb_t colour;

  assign cell_x = 2'(pix.x / cell_w);
  assign cell_y = 2'(pix.y / cell_h);
  assign off_x  = coord_w'(pix.x % cell_w);
  assign off_y  = coord_w'(pix.y % cell_h);
  assign tile   = board[cell_x][cell_y];

  // leading edge of every cell plus the closing right and bottom lines
  assign border = (off_x < coord_w'(border_w)) || (off_y < coord_w'(border_w)) ||
                  (pix.x >= coord_w'(h_active - border_w)) ||
                  (pix.y >= coord_w'(v_active - border_w));

  always_comb begin
    if (!pix.active) begin
      colour = '0;            // blanking
    end else if (border) begin
      colour = border_rgb;
    end else if (tile > max_tile) begin
      colour = '0;
    end else begin
      colour = palette[tile];
    end
  end

  // colour and sync leave together, one cycle behind the counters
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      red   <= 2'b00;
      green <= 2'b00;
      blue  <= 2'b00;
      hsync <= 1'b1;  // idle, not in sync
      vsync <= 1'b1;
    end else begin
      red   <= colour.red;
      green <= colour.green;
      blue  <= colour.blue;
      hsync <= pix.hsync;
      vsync <= pix.vsync;
    end
  end

endmodule

/* hw/vga_timing.sv */
`timescale 1ns/100ps

module vga_timing #(
  parameter int h_active = 640,
  parameter int h_front  = 16,
  parameter int h_sync   = 96,
  parameter int h_back   = 48,
  parameter int v_active = 480,
  parameter int v_front  = 10,
  parameter int v_sync   = 2,
  parameter int v_back   = 33,
  parameter int coord_w  = 10
) (
  input  logic clk,
  input  logic rst_n,
  pixel_if.src pix
);

  localparam int h_total = h_active + h_front + h_sync + h_back;
  localparam int v_total = v_active + v_front + v_sync + v_back;

  logic [coord_w-1:0] h_cnt;  // pixel in line
  logic [coord_w-1:0] v_cnt;  // line in frame

  // starts on the first visible pixel
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      h_cnt <= '0;
      v_cnt <= '0;
    end else if (h_cnt == coord_w'(h_total - 1)) begin
      h_cnt <= '0;
      if (v_cnt == coord_w'(v_total - 1)) begin
        v_cnt <= '0;  // frame wrap
      end else begin
        v_cnt <= v_cnt + 1'b1;
      end
    end else begin
      h_cnt <= h_cnt + 1'b1;
    end
  end

  assign pix.x = h_cnt;
  assign pix.y = v_cnt;
  assign pix.active = (h_cnt < coord_w'(h_active)) && (v_cnt < coord_w'(v_active));

  // sync windows follow the front porch, low while inside
  assign pix.hsync = !((h_cnt >= coord_w'(h_active + h_front)) &&
                       (h_cnt < coord_w'(h_active + h_front + h_sync)));
  assign pix.vsync = !((v_cnt >= coord_w'(v_active + v_front)) &&
                       (v_cnt < coord_w'(v_active + v_front + v_sync)));

endmodule

/* list.f */
hw/game_pkg.sv
hw/game_if.sv
hw/pad_receiver.sv
hw/move_detect.sv
hw/board_engine.sv
hw/vga_timing.sv
hw/tile_renderer.sv
hw/game_2048_top.sv
test/game_properties.sv
test/tb_game.sv

/* run.sh */
#!/bin/sh
# build with verilator, run, pass only when the pass line appears
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert --top-module tb_game -f list.f -Mdir obj_dir &&
  ./obj_dir/Vtb_game | tee /dev/stderr | grep -qx '>>> PASS' &&
  echo "simulation passed" ||
  { echo "simulation failed"; exit 1; }

/* test/game_properties.sv */
`timescale 1ns/100ps

module game_properties (
  input logic clk,
  input logic rst_n,
  input game_pkg::board_t board,
  input logic spawn_en,
  input logic any_move,
  input logic present,
  input logic [3:0] strobes   // up, down, left, right
);
  import game_pkg::*;

  for (genvar x = 0; x < 4; x++) begin : col
    for (genvar y = 0; y < 4; y++) begin : row
      tile_range: assert property (@(posedge clk) disable iff (!rst_n)
        board[x][y] <= max_tile)
        else $error("tile above max_tile at board[%0d][%0d]", x, y);
    end
  end

  // spawn follows a move whose write really altered the board
  spawn_after_move: assert property (@(posedge clk) disable iff (!rst_n)
    spawn_en |-> ($past(any_move) && (board != $past(board))))
    else $error("spawn write without a changed move before it");

  // strobes are registered, so look one cycle on
  quiet_without_pad: assert property (@(posedge clk) disable iff (!rst_n)
    !present |=> (strobes == 4'h0))
    else $error("move strobe while no pad is present");

endmodule

bind board_engine game_properties engine_props_i (
  .clk      (clk),
  .rst_n    (rst_n),
  .board    (board),
  .spawn_en (spawn_en),
  .any_move (any_move),
  .present  (1'b1),
  .strobes  (4'h0)
);

bind move_detect game_properties detect_props_i (
  .clk      (clk),
  .rst_n    (rst_n),
  .board    ('0),
  .spawn_en (1'b0),
  .any_move (1'b0),
  .present  (present),
  .strobes  ({moves.up, moves.down, moves.left, moves.right})
);

/* test/tb_game.sv */
`timescale 1ns/100ps

module tb_game;
  import game_pkg::*;

  // small screen, 32x24 visible
  localparam int h_active = 32;
  localparam int h_front  = 2;
  localparam int h_sync   = 4;
  localparam int h_back   = 2;
  localparam int v_active = 24;
  localparam int v_front  = 1;
  localparam int v_sync   = 2;
  localparam int v_back   = 1;
  localparam int cell_w   = 8;
  localparam int cell_h   = 6;
  localparam int border_w = 1;
  localparam int h_total  = h_active + h_front + h_sync + h_back;
  localparam int v_total  = v_active + v_front + v_sync + v_back;
  localparam int frame_cycles = h_total * v_total;
  localparam int pad_cycles   = 12 * 8 + 13;          // align, bits, latch, gap
  // one check is two pad frames plus at most two screen frames
  localparam int check_cycles = 2 * pad_cycles + 2 * frame_cycles + 64;
  localparam int max_checks   = 26;                   // reset, absent, up to 24 moves
  localparam int cycle_limit  = max_checks * check_cycles + 1000;

  logic clk;
  logic rst_n;
  logic pmod_data;
  logic pmod_clk;
  logic pmod_latch;
  logic hsync;
  logic vsync;
  logic [1:0] red;
  logic [1:0] green;
  logic [1:0] blue;

  int errors;
  int checks;
  int cycles;
  int seed;
  int tx;               // pixel now on the outputs
  int ty;
  board_t model;        // board as the testbench believes it
  board_t screen;       // read back from cell centres
  board_t exp_board;
  bit exp_changed;
  event frame_done;
  event check_req;
  event check_done;

  game_2048_top #(
    .h_active (h_active),
    .h_front  (h_front),
    .h_sync   (h_sync),
    .h_back   (h_back),
    .v_active (v_active),
    .v_front  (v_front),
    .v_sync   (v_sync),
    .v_back   (v_back),
    .cell_w   (cell_w),
    .cell_h   (cell_h),
    .border_w (border_w)
  ) dut_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .pmod_data  (pmod_data),
    .pmod_clk   (pmod_clk),
    .pmod_latch (pmod_latch),
    .hsync      (hsync),
    .vsync      (vsync),
    .red        (red),
    .green      (green),
    .blue       (blue)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #20 clk = ~clk;
    end
  end

  // n edges, then just past the edge
  task automatic step(input int n);
    repeat (n) @(posedge clk);
    #2;
  endtask

  // msb first, latch pulse after the last bit
  task automatic send_frame(input logic [11:0] frame);
    step(1);              // line up with the clock
    for (int i = 11; i >= 0; i--) begin
      pmod_data = frame[i];
      pmod_clk  = 1'b0;
      step(4);
      pmod_clk  = 1'b1;   // shift on this rise
      step(4);
    end
    pmod_latch = 1'b1;
    step(4);
    pmod_latch = 1'b0;
    pmod_data  = 1'b1;  // idle high
    step(8);
  endtask

  // line ln, position k from the head; 0 up, 1 down, 2 left, 3 right
  function automatic int line_col(input int dir, input int ln, input int k);
    case (dir)
      0, 1:    return ln;
      2:       return k;
      default: return 3 - k;
    endcase
  endfunction

  function automatic int line_row(input int dir, input int ln, input int k);
    case (dir)
      0:       return k;
      1:       return 3 - k;
      default: return ln;
    endcase
  endfunction

  // gather tiles toward the head, each pair merges once, head first
  function automatic board_t ref_move(input board_t b, input int dir);
    board_t r;
    int vals[4];
    int cnt;
    int pos;
    int i;
    int v;
    r = '0;
    for (int ln = 0; ln < 4; ln++) begin
      cnt = 0;
      for (int k = 0; k < 4; k++) begin
        v = int'(b[line_col(dir, ln, k)][line_row(dir, ln, k)]);
        if (v != 0) begin
          vals[cnt] = v;
          cnt++;
        end
      end
      pos = 0;
      i = 0;
      while (i < cnt) begin
        if (i + 1 < cnt && vals[i] == vals[i+1] && vals[i] < int'(max_tile)) begin
          v = vals[i] + 1;  // merged pair
          i = i + 2;
        end else begin
          v = vals[i];
          i = i + 1;
        end
        r[line_col(dir, ln, pos)][line_row(dir, ln, pos)] = tile_t'(v);
        pos++;
      end
    end
    return r;
  endfunction

  // back from colour to tile value, 15 when no palette entry fits
  function automatic tile_t colour_to_tile(input rgb_t c);
    tile_t t;
    t = 4'hf;
    for (int i = 0; i < 12; i++) begin
      if (palette[i] == c) begin
        t = tile_t'(i);
      end
    end
    return t;
  endfunction

  function automatic bit is_border(input int x, input int y);
    return (x % cell_w < border_w) || (y % cell_h < border_w) ||
           (x >= h_active - border_w) || (y >= v_active - border_w);
  endfunction

  // own raster, one cycle behind the dut counters
  initial begin : scan
    rgb_t seen_rgb;
    bit in_hsync;
    bit in_vsync;
    tx = 0;
    ty = 0;
    screen = '0;
    @(posedge rst_n);
    @(posedge clk);     // first registered pixel is (0,0)
    forever begin
      @(negedge clk);
      seen_rgb = {red, green, blue};
      in_hsync = (tx >= h_active + h_front) && (tx < h_active + h_front + h_sync);
      in_vsync = (ty >= v_active + v_front) && (ty < v_active + v_front + v_sync);
      if (tx < h_active && ty < v_active) begin
        if (is_border(tx, ty)) begin
          if (seen_rgb != border_rgb) begin
            errors++;
            $display("mismatch at %0t ns: rgb at (%0d,%0d) expected %h got %h",
                     $time, tx, ty, border_rgb, seen_rgb);
          end
        end else if (tx % cell_w == cell_w / 2 && ty % cell_h == cell_h / 2) begin
          screen[tx / cell_w][ty / cell_h] = colour_to_tile(seen_rgb);  // cell centre
        end
      end else if (seen_rgb != '0) begin
        errors++;   // blanking, sync included
        $display("mismatch at %0t ns: rgb at (%0d,%0d) in blanking expected 00 got %h",
                 $time, tx, ty, seen_rgb);
      end
      if (hsync !== !in_hsync) begin
        errors++;
        $display("mismatch at %0t ns: hsync at x=%0d expected %b got %b",
                 $time, tx, !in_hsync, hsync);
      end
      if (vsync !== !in_vsync) begin
        errors++;
        $display("mismatch at %0t ns: vsync at y=%0d expected %b got %b",
                 $time, ty, !in_vsync, vsync);
      end
      if (tx == h_total - 1) begin
        tx = 0;
        if (ty == v_total - 1) begin
          ty = 0;
          -> frame_done;
        end else begin
          ty++;
        end
      end else begin
        tx++;
      end
    end
  end

  // compare the scanned board against the reference
  always begin : compare
    int spawns;
    int empties;
    @(check_req);
    repeat (2) @(frame_done);  // one whole frame after the change
    spawns  = 0;
    empties = 0;
    for (int x = 0; x < 4; x++) begin
      for (int y = 0; y < 4; y++) begin
        if (exp_board[x][y] == 4'd0) begin
          empties++;
        end
      end
    end
    for (int x = 0; x < 4; x++) begin
      for (int y = 0; y < 4; y++) begin
        checks++;
        if (screen[x][y] != exp_board[x][y]) begin
          if (exp_changed && exp_board[x][y] == 4'd0 &&
              (screen[x][y] == 4'd1 || screen[x][y] == 4'd2)) begin
            spawns++;   // new tile in a slot left empty
          end else begin
            errors++;
            $display("mismatch at %0t ns: board[%0d][%0d] expected %0d got %0d",
                     $time, x, y, exp_board[x][y], screen[x][y]);
          end
        end
      end
    end
    if (exp_changed && empties > 0 && spawns != 1) begin
      errors++;
      $display("error at %0t ns: a changed move should add one tile, found %0d new tiles",
               $time, spawns);
    end
    -> check_done;
  end

  task automatic run_check(input board_t exp, input bit chg);
    exp_board   = exp;
    exp_changed = chg;
    -> check_req;
    @(check_done);
    model = screen;   // adopt the spawn
  endtask

  // press then release one direction
  task automatic do_move(input int dir);
    board_t exp;
    pad_word_u f;
    exp = ref_move(model, dir);
    f.raw = '0;
    case (dir)
      0:       f.btn.up = 1'b1;
      1:       f.btn.down = 1'b1;
      2:       f.btn.left = 1'b1;
      default: f.btn.right = 1'b1;
    endcase
    send_frame(f.raw);
    send_frame(12'h000);
    run_check(exp, exp != model);
  endtask

  initial begin : watchdog
    cycles = 0;
    while (cycles < cycle_limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: no result after %0d cycles", cycles);
    $display(">>> FAIL");
    $finish;
  end

  initial begin : main
    pad_word_u f;
    bit covered[4];
    bit found;
    int dir;
    int tries;
    errors     = 0;
    checks     = 0;
    seed       = 58424;
    rst_n      = 1'b0;
    pmod_data  = 1'b1;
    pmod_clk   = 1'b1;
    pmod_latch = 1'b0;
    model      = '0;
    model[1][1] = 4'd1;   // starting tiles
    model[2][2] = 4'd1;
    covered    = '{0, 0, 0, 0};
    step(5);
    rst_n = 1'b1;

    run_check(model, 1'b0);   // reset board
    // no pad, then a frame with up cleared and nothing rising
    send_frame(12'hfff);
    f.raw = '1;
    f.btn.up = 1'b0;
    send_frame(f.raw);
    run_check(model, 1'b0);
    send_frame(12'h000);      // all released

    do_move(2);
    covered[2] = 1'b1;
    tries = 0;
    while (ref_move(model, 2) != model && tries < 6) begin
      do_move(2);
      tries++;
    end
    found = 1'b0;
    for (int d = 0; d < 4; d++) begin
      if (!found && ref_move(model, d) == model) begin
        found = 1'b1;
        do_move(d);           // board must stay put
      end
    end
    if (!found) begin
      $display("note: every direction changes the board, no-change step skipped");
    end

    for (int n = 0; n < 12; n++) begin
      dir = $unsigned($random(seed)) % 4;
      covered[dir] = 1'b1;
      do_move(dir);
    end
    for (int d = 0; d < 4; d++) begin
      if (!covered[d]) begin
        do_move(d);
      end
    end

    $display("errors: %0d, cells checked: %0d", errors, checks);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule
